/* hw/core_defs.svh */
// size macros and APB address map of the mini core
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define CORE_DW          16       // register and alu width
`define CORE_IW          16       // instruction word width
`define CORE_IMEM_DEPTH  64       // instruction words
`define CORE_NREGS       8        // r0 .. r7
`define CORE_PADDR_W     12       // apb address width
`define CORE_PDATA_W     32       // apb data width

`define CORE_ADDR_IMEM   12'h000  // imem words at 4-byte steps
`define CORE_ADDR_CTRL   12'h100  // bit 0 start / run
`define CORE_ADDR_STATUS 12'h104  // host state in bits 1:0
`define CORE_ADDR_REGS   12'h180  // r0 .. r7 at 4-byte steps

`endif

/* hw/core_pkg.sv */
// opcode and host state enums, instruction and stage register structs
`include "core_defs.svh"

package core_pkg;

    localparam int PC_W = $clog2(`CORE_IMEM_DEPTH);  // pc / imem index width
    localparam int RA_W = $clog2(`CORE_NREGS);       // register address width

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LDI  = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_JMP  = 4'd7,
        OP_HALT = 4'd8
    } opcode_e;

    typedef enum logic [1:0] {
        HOST_IDLE    = 2'd0,
        HOST_RUNNING = 2'd1,
        HOST_HALTED  = 2'd2
    } host_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [RA_W-1:0] rs1;
        logic [RA_W-1:0] rs2;
        logic [2:0]      spare;     // unused
    } rr_fields_t;

    typedef struct packed {
        logic [7:0] imm;            // ldi value, jmp target in low six bits
        logic       spare;
    } ri_fields_t;

    typedef union packed {
        rr_fields_t rr;
        ri_fields_t ri;
    } instr_body_u;

    typedef struct packed {
        opcode_e         opcode;    // bits 15:12
        logic [RA_W-1:0] rd;        // bits 11:9
        instr_body_u     body;      // bits 8:0
    } instr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic            valid;
        instr_t          instr;
        logic [PC_W-1:0] pc;
    } if_id_t;

    typedef struct packed {
        logic             valid;
        opcode_e          opcode;
        logic [RA_W-1:0]  rd;
        logic [`CORE_DW-1:0] op_a;
        logic [`CORE_DW-1:0] op_b;   // also the ldi immediate
        logic [PC_W-1:0]  target;
    } id_ex_t;

endpackage

/* hw/gen_dff.sv */
// generic flip-flops: flushable pipe register and enable register
`timescale 1ns/1ps

// stage register, reset or hold loads the default value
module gen_pipe_dff #(
    parameter int unsigned DW = 32
) (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          hold_i,     // flush / stall to default
    input  logic [DW-1:0] def_val_i,
    input  logic [DW-1:0] din_i,
    output logic [DW-1:0] qout_o
);

    logic [DW-1:0] qout_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni || hold_i) begin
            qout_q <= def_val_i;          // nop bubble
        end else begin
            qout_q <= din_i;
        end
    end

    assign qout_o = qout_q;

endmodule

// enable register, clears to zero on reset
module gen_en_dff #(
    parameter int unsigned DW = 32
) (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          en_i,
    input  logic [DW-1:0] din_i,
    output logic [DW-1:0] qout_o
);

    logic [DW-1:0] qout_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            qout_q <= '0;
        end else if (en_i) begin
            qout_q <= din_i;              // load only when enabled
        end
    end

    assign qout_o = qout_q;

endmodule

/* hw/reg_file.sv */
// register file: eight registers, one write port, three read ports
`timescale 1ns/1ps
`include "core_defs.svh"

module reg_file import core_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                wr_en_i,
    input  logic [RA_W-1:0]     wr_addr_i,
    input  logic [`CORE_DW-1:0] wr_data_i,
    input  logic [RA_W-1:0]     rs1_addr_i,
    input  logic [RA_W-1:0]     rs2_addr_i,
    input  logic [RA_W-1:0]     host_addr_i,
    output logic [`CORE_DW-1:0] rs1_data_o,
    output logic [`CORE_DW-1:0] rs2_data_o,
    output logic [`CORE_DW-1:0] host_data_o
);

    logic [`CORE_DW-1:0] regs_q [`CORE_NREGS];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs_q[wr_addr_i] <= wr_data_i;  // write-back at end of execute
        end
    end

    assign rs1_data_o  = regs_q[rs1_addr_i];  // decode port a
    assign rs2_data_o  = regs_q[rs2_addr_i];  // decode port b
    assign host_data_o = regs_q[host_addr_i]; // apb read window

endmodule

/* hw/exec_stage.sv */
// execute stage: alu, register write-back, jump and halt detection
`timescale 1ns/1ps
`include "core_defs.svh"

module exec_stage import core_pkg::*; (
    input  id_ex_t              id_ex_i,
    output logic                wr_en_o,        // also the forwarding valid
    output logic [RA_W-1:0]     wr_addr_o,
    output logic [`CORE_DW-1:0] wr_data_o,
    output logic                jump_o,
    output logic [PC_W-1:0]     jump_target_o,
    output logic                halt_o,
    output logic                flush_o
);

    assign wr_addr_o     = id_ex_i.rd;
    assign jump_target_o = id_ex_i.target;

    always_comb begin
        wr_en_o   = 1'b0;
        wr_data_o = '0;
        jump_o    = 1'b0;
        halt_o    = 1'b0;
        if (id_ex_i.valid) begin           // bubbles do nothing
            unique case (id_ex_i.opcode)
                OP_LDI:  begin wr_en_o = 1'b1; wr_data_o = id_ex_i.op_b; end
                OP_ADD:  begin wr_en_o = 1'b1; wr_data_o = id_ex_i.op_a + id_ex_i.op_b; end
                OP_SUB:  begin wr_en_o = 1'b1; wr_data_o = id_ex_i.op_a - id_ex_i.op_b; end
                OP_AND:  begin wr_en_o = 1'b1; wr_data_o = id_ex_i.op_a & id_ex_i.op_b; end
                OP_OR:   begin wr_en_o = 1'b1; wr_data_o = id_ex_i.op_a | id_ex_i.op_b; end
                OP_XOR:  begin wr_en_o = 1'b1; wr_data_o = id_ex_i.op_a ^ id_ex_i.op_b; end
                OP_JMP:  jump_o = 1'b1;
                OP_HALT: halt_o = 1'b1;
                default: ;                 // nop and unused codes
            endcase
        end
    end

    // both younger instructions are dropped on jmp or halt
    assign flush_o = jump_o | halt_o;

endmodule

/* hw/decode_stage.sv */
// decode stage: field split, operand select with forwarding, id/ex register
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_stage import core_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                run_i,
    input  logic                flush_i,
    input  if_id_t              if_id_i,
    output logic [RA_W-1:0]     rs1_addr_o,
    output logic [RA_W-1:0]     rs2_addr_o,
    input  logic [`CORE_DW-1:0] rs1_data_i,
    input  logic [`CORE_DW-1:0] rs2_data_i,
    input  logic                fwd_en_i,     // execute writes this cycle
    input  logic [RA_W-1:0]     fwd_addr_i,
    input  logic [`CORE_DW-1:0] fwd_data_i,
    output id_ex_t              id_ex_o
);

    localparam id_ex_t ID_EX_NOP = '0;

    instr_t              instr;
    logic [`CORE_DW-1:0] imm_ext;
    logic [`CORE_DW-1:0] src_a;
    logic [`CORE_DW-1:0] src_b;
    logic                id_hold;
    id_ex_t              id_ex_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign instr      = if_id_i.instr;
    assign rs1_addr_o = instr.body.rr.rs1;
    assign rs2_addr_o = instr.body.rr.rs2;
    assign imm_ext    = {{(`CORE_DW-8){1'b0}}, instr.body.ri.imm};  // zero extend

    // older instruction in execute wins over the register file
    assign src_a = (fwd_en_i && fwd_addr_i == rs1_addr_o) ? fwd_data_i : rs1_data_i;
    assign src_b = (fwd_en_i && fwd_addr_i == rs2_addr_o) ? fwd_data_i : rs2_data_i;

    always_comb begin
        id_ex_d        = ID_EX_NOP;
        id_ex_d.valid  = if_id_i.valid;
        id_ex_d.opcode = instr.opcode;
        id_ex_d.rd     = instr.rd;
        id_ex_d.op_a   = src_a;
        id_ex_d.op_b   = (instr.opcode == OP_LDI) ? imm_ext : src_b;
        id_ex_d.target = instr.body.ri.imm[PC_W-1:0];   // jmp only
    end

    assign id_hold = ~run_i | flush_i;     // same bubble rule as if/id

    gen_pipe_dff #(.DW($bits(id_ex_t))) u_id_ex (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .hold_i   (id_hold),
        .def_val_i(ID_EX_NOP),
        .din_i    (id_ex_d),
        .qout_o   (id_ex_o)
    );

endmodule

/* hw/fetch_stage.sv */
// fetch stage: pc register, imem address, jump redirect, if/id register
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch_stage import core_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                run_i,
    input  logic                start_i,
    input  logic                jump_i,
    input  logic [PC_W-1:0]     jump_target_i,
    input  logic                flush_i,
    output logic [PC_W-1:0]     imem_addr_o,
    input  logic [`CORE_IW-1:0] imem_rdata_i,
    output if_id_t              if_id_o
);

    localparam if_id_t IF_ID_NOP = '0;     // invalid nop

    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_d;
    logic            pc_en;
    logic            if_hold;
    if_id_t          if_id_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (start_i) begin
            pc_d = '0;                     // restart from word 0
        end else if (jump_i) begin
            pc_d = jump_target_i;
        end else begin
            pc_d = pc_q + 1'b1;            // wraps at imem depth
        end
    end

    assign pc_en = run_i | start_i;        // frozen while idle or halted

    gen_en_dff #(.DW(PC_W)) u_pc (
        .clk_i (clk_i),
        .rst_ni(rst_ni),
        .en_i  (pc_en),
        .din_i (pc_d),
        .qout_o(pc_q)
    );

    assign imem_addr_o = pc_q;             // combinational imem read

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign if_id_d.valid = 1'b1;
    assign if_id_d.instr = imem_rdata_i;
    assign if_id_d.pc    = pc_q;

    assign if_hold = ~run_i | start_i | flush_i;

    gen_pipe_dff #(.DW($bits(if_id_t))) u_if_id (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .hold_i   (if_hold),
        .def_val_i(IF_ID_NOP),
        .din_i    (if_id_d),
        .qout_o   (if_id_o)
    );

endmodule

/* hw/apb_host_port.sv */
// APB slave: instruction memory, control/status FSM, register read window
`timescale 1ns/1ps
`include "core_defs.svh"

module apb_host_port import core_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [`CORE_PADDR_W-1:0] paddr_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [`CORE_PDATA_W-1:0] pwdata_i,
    output logic [`CORE_PDATA_W-1:0] prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    input  logic                     halt_i,
    input  logic [PC_W-1:0]          imem_addr_i,
    output logic                     run_o,
    output logic                     start_o,
    output logic [`CORE_IW-1:0]      imem_rdata_o,
    output logic [RA_W-1:0]          reg_addr_o,
    input  logic [`CORE_DW-1:0]      reg_data_i
);

    localparam logic [`CORE_PADDR_W-1:0] IMEM_BASE = `CORE_ADDR_IMEM;
    localparam logic [`CORE_PADDR_W-1:0] REGS_BASE = `CORE_ADDR_REGS;
    localparam logic [`CORE_PADDR_W-1:0] IMEM_SPAN = `CORE_PADDR_W'(`CORE_IMEM_DEPTH * 4);
    localparam logic [`CORE_PADDR_W-1:0] REGS_SPAN = `CORE_PADDR_W'(`CORE_NREGS * 4);

    logic [`CORE_IW-1:0]      imem [`CORE_IMEM_DEPTH];
    host_state_e              state_q;
    host_state_e              state_d;
    logic                     start_q;
    logic                     access;
    logic [`CORE_PADDR_W-1:0] imem_off;
    logic [`CORE_PADDR_W-1:0] regs_off;
    logic                     imem_hit;
    logic                     ctrl_hit;
    logic                     status_hit;
    logic                     regs_hit;
    logic                     ctrl_wr;
    logic                     imem_wr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign access     = psel_i & penable_i;          // no wait states
    assign imem_off   = paddr_i - IMEM_BASE;
    assign regs_off   = paddr_i - REGS_BASE;
    assign imem_hit   = (imem_off < IMEM_SPAN) && (paddr_i[1:0] == 2'b00);
    assign regs_hit   = (regs_off < REGS_SPAN) && (paddr_i[1:0] == 2'b00);
    assign ctrl_hit   = (paddr_i == `CORE_ADDR_CTRL);
    assign status_hit = (paddr_i == `CORE_ADDR_STATUS);
    assign reg_addr_o = regs_off[RA_W+1:2];

    assign ctrl_wr = access & pwrite_i & ctrl_hit;
    assign imem_wr = access & pwrite_i & imem_hit & ~run_o;  // locked while running

    assign pready_o  = 1'b1;
    assign pslverr_o = access & (~(imem_hit | regs_hit | ctrl_hit | status_hit)
                               | (pwrite_i & imem_hit & run_o));

    always_comb begin
        prdata_o = '0;
        if (imem_hit) begin
            prdata_o[`CORE_IW-1:0] = imem[imem_off[PC_W+1:2]];  // zero extended
        end else if (ctrl_hit) begin
            prdata_o[0] = run_o;
        end else if (status_hit) begin
            prdata_o[1:0] = state_q;
        end else if (regs_hit) begin
            prdata_o[`CORE_DW-1:0] = reg_data_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (imem_wr) begin
            imem[imem_off[PC_W+1:2]] <= pwdata_i[`CORE_IW-1:0];
        end
    end

    assign imem_rdata_o = imem[imem_addr_i];  // fetch port

    // host state, a ctrl write wins over a halt in the same cycle
    always_comb begin
        state_d = state_q;
        if (ctrl_wr) begin
            state_d = pwdata_i[0] ? HOST_RUNNING : HOST_IDLE;
        end else if (halt_i && state_q == HOST_RUNNING) begin
            state_d = HOST_HALTED;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= HOST_IDLE;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= ctrl_wr & pwdata_i[0];  // one-cycle pulse
        end
    end

    assign run_o   = (state_q == HOST_RUNNING);
    assign start_o = start_q;

endmodule

/* hw/mini_core_top.sv */
// top level: host port, three pipeline stages and register file
`timescale 1ns/1ps
`include "core_defs.svh"

module mini_core_top import core_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [`CORE_PADDR_W-1:0] paddr_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [`CORE_PDATA_W-1:0] pwdata_i,
    output logic [`CORE_PDATA_W-1:0] prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o
);

    logic                run;
    logic                start;
    logic                halt;
    logic                flush;
    logic                jump;
    logic [PC_W-1:0]     jump_target;
    logic [PC_W-1:0]     imem_addr;
    logic [`CORE_IW-1:0] imem_rdata;
    if_id_t              if_id;
    id_ex_t              id_ex;
    logic [RA_W-1:0]     rs1_addr;
    logic [RA_W-1:0]     rs2_addr;
    logic [`CORE_DW-1:0] rs1_data;
    logic [`CORE_DW-1:0] rs2_data;
    logic                wr_en;      // write-back, doubles as forwarding bus
    logic [RA_W-1:0]     wr_addr;
    logic [`CORE_DW-1:0] wr_data;
    logic [RA_W-1:0]     reg_addr;
    logic [`CORE_DW-1:0] reg_data;

    apb_host_port u_host (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o),
        .halt_i(halt), .imem_addr_i(imem_addr), .run_o(run), .start_o(start),
        .imem_rdata_o(imem_rdata), .reg_addr_o(reg_addr), .reg_data_i(reg_data)
    );

    fetch_stage u_fetch (
        .clk_i(clk_i), .rst_ni(rst_ni), .run_i(run), .start_i(start),
        .jump_i(jump), .jump_target_i(jump_target), .flush_i(flush),
        .imem_addr_o(imem_addr), .imem_rdata_i(imem_rdata), .if_id_o(if_id)
    );

    decode_stage u_decode (
        .clk_i(clk_i), .rst_ni(rst_ni), .run_i(run), .flush_i(flush),
        .if_id_i(if_id), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .fwd_en_i(wr_en), .fwd_addr_i(wr_addr), .fwd_data_i(wr_data),
        .id_ex_o(id_ex)
    );

    exec_stage u_exec (
        .id_ex_i(id_ex), .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
        .jump_o(jump), .jump_target_o(jump_target), .halt_o(halt), .flush_o(flush)
    );

    reg_file u_regs (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr), .host_addr_i(reg_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .host_data_o(reg_data)
    );

endmodule

/* bench/mini_core_properties.sv */
// concurrent assertions on the APB handshake and pipeline control of the mini core
`timescale 1ns/1ps

module mini_core_properties (
    input logic clk_i,
    input logic rst_ni,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i,
    input logic run_i,
    input logic jump_i,
    input logic flush_i
);

    logic        access;
    int unsigned fail_cnt = 0;              // failed assertion count

    assign access = psel_i & penable_i;     // apb access phase

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    pready_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
        access |-> pready_i)
        else begin
            fail_cnt++;
            $error("pready low in an access phase");
        end

    slverr_only_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !access |-> !pslverr_i)
        else begin
            fail_cnt++;
            $error("pslverr high outside an access phase");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    jump_flushes: assert property (@(posedge clk_i) disable iff (!rst_ni)
        jump_i |-> flush_i)
        else begin
            fail_cnt++;
            $error("jump without flush of the younger stages");
        end

    // not gated by reset so the reset cycles themselves are covered
    idle_after_reset: assert property (@(posedge clk_i)
        !rst_ni |=> !run_i)
        else begin
            fail_cnt++;
            $error("core running during or right after reset");
        end

endmodule

/* bench/mini_core_tb.sv */
// clock, reset, APB tasks, programs, reference model and checks for the mini core
`timescale 1ns/1ps
`include "core_defs.svh"

module mini_core_tb import core_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;  // tests need well under 1k cycles

    logic                     clk;
    logic                     rst_n;
    logic [`CORE_PADDR_W-1:0] paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`CORE_PDATA_W-1:0] pwdata;
    logic [`CORE_PDATA_W-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
    logic [`CORE_IW-1:0]      prog [`CORE_IMEM_DEPTH];   // mirror of the imem contents
    logic [`CORE_DW-1:0]      exp_regs [`CORE_NREGS];    // reference register state
    int                       prog_len;
    int                       seed;
    int                       checks;
    int                       errors;
    int                       cycles = 0;

    mini_core_top u_mini_core_top (
        .clk_i(clk), .rst_ni(rst_n),
        .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
    );

    bind mini_core_top mini_core_properties u_props (
        .clk_i(clk_i), .rst_ni(rst_ni), .psel_i(psel_i), .penable_i(penable_i),
        .pready_i(pready_o), .pslverr_i(pslverr_o),
        .run_i(run), .jump_i(jump), .flush_i(flush)
    );

    always #5 clk = ~clk;                   // 10 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
        paddr   = addr;                     // setup phase
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;                     // access phase lands at the next posedge
        #1;
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;                      // valid during access
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encodings op rd rs1 rs2 spare or op rd imm8 spare
    function automatic logic [15:0] enc_rr(logic [3:0] op, int rd, int rs1, int rs2);
        return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
    endfunction

    function automatic logic [15:0] enc_ri(logic [3:0] op, int rd, logic [7:0] imm);
        return {op, 3'(rd), imm, 1'b0};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic emit(input logic [15:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // executes the mirrored program one instruction at a time
    task automatic run_model();
        int          pc;
        int          steps;
        logic        done;
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 1000) begin
            w  = prog[pc];
            a  = exp_regs[w[8:6]];
            b  = exp_regs[w[5:3]];
            pc = (pc + 1) % `CORE_IMEM_DEPTH;
            steps++;
            case (w[15:12])
                OP_LDI:  exp_regs[w[11:9]] = {8'h00, w[8:1]};   // zero extended imm
                OP_ADD:  exp_regs[w[11:9]] = a + b;
                OP_SUB:  exp_regs[w[11:9]] = a - b;
                OP_AND:  exp_regs[w[11:9]] = a & b;
                OP_OR:   exp_regs[w[11:9]] = a | b;
                OP_XOR:  exp_regs[w[11:9]] = a ^ b;
                OP_JMP:  pc = int'(w[6:1]);                      // low six imm bits
                OP_HALT: done = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic check_regs();
        logic [31:0] d;
        logic        err;
        for (int i = 0; i < `CORE_NREGS; i++) begin
            apb_read(`CORE_ADDR_REGS + 12'(4 * i), d, err);
            check_eq($sformatf("prdata r%0d", i), {16'h0, exp_regs[i]}, d);
        end
    endtask

    task automatic load_program();
        logic err;
        for (int i = 0; i < prog_len; i++) begin
            apb_write(`CORE_ADDR_IMEM + 12'(4 * i), {16'h0, prog[i]}, err);
        end
    endtask

    task automatic start_and_check();
        logic [31:0] d;
        logic        err;
        run_model();
        apb_write(`CORE_ADDR_CTRL, 32'h1, err);
        do begin
            apb_read(`CORE_ADDR_STATUS, d, err);   // poll until the core halts
        end while (d[1:0] != HOST_HALTED);
        check_regs();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] d;
        logic [31:0] rnd;
        logic        err;
        logic [15:0] old;
        clk      = 1'b0;
        rst_n    = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        seed     = 71;
        checks   = 0;
        errors   = 0;
        prog_len = 0;
        for (int i = 0; i < `CORE_NREGS; i++) begin
            exp_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // reset state then random imem words read back
        apb_read(`CORE_ADDR_STATUS, d, err);
        check_eq("prdata status", 32'(HOST_IDLE), d);
        check_regs();
        for (int i = 0; i < `CORE_IMEM_DEPTH; i++) begin
            rnd     = $random(seed);
            prog[i] = rnd[15:0];
            apb_write(`CORE_ADDR_IMEM + 12'(4 * i), {16'h0, prog[i]}, err);
        end
        for (int i = 0; i < `CORE_IMEM_DEPTH; i++) begin
            apb_read(`CORE_ADDR_IMEM + 12'(4 * i), d, err);
            check_eq($sformatf("prdata imem[%0d]", i), {16'h0, prog[i]}, d);
        end

        // every alu op with sources settled by nops
        prog_len = 0;
        emit(enc_ri(OP_LDI, 1, rand_byte()));
        emit(enc_ri(OP_LDI, 2, rand_byte()));
        emit(16'h0000);
        emit(16'h0000);
        emit(enc_rr(OP_ADD, 3, 1, 2));
        emit(enc_rr(OP_SUB, 4, 1, 2));
        emit(enc_rr(OP_AND, 5, 1, 2));
        emit(enc_rr(OP_OR, 6, 1, 2));
        emit(enc_rr(OP_XOR, 7, 1, 2));
        emit(enc_ri(OP_HALT, 0, 8'h00));
        load_program();
        start_and_check();

        // back-to-back dependent chain through the forward path on both operands
        prog_len = 0;
        emit(enc_ri(OP_LDI, 1, rand_byte()));
        emit(enc_ri(OP_LDI, 2, rand_byte()));
        emit(enc_rr(OP_ADD, 3, 1, 2));
        emit(enc_rr(OP_SUB, 4, 3, 1));
        emit(enc_rr(OP_XOR, 5, 4, 3));
        emit(enc_rr(OP_ADD, 5, 5, 2));
        emit(enc_rr(OP_XOR, 0, 5, 1));
        emit(enc_rr(OP_SUB, 7, 4, 0));
        emit(enc_ri(OP_HALT, 0, 8'h00));
        load_program();
        start_and_check();

        // jmp over three ldi words so r2..r4 keep their old values
        prog_len = 0;
        emit(enc_ri(OP_LDI, 1, rand_byte()));
        emit(enc_ri(OP_JMP, 0, 8'd5));
        emit(enc_ri(OP_LDI, 2, rand_byte()));
        emit(enc_ri(OP_LDI, 3, rand_byte()));
        emit(enc_ri(OP_LDI, 4, rand_byte()));
        emit(enc_ri(OP_LDI, 5, rand_byte()));
        emit(enc_rr(OP_ADD, 6, 6, 5));               // r6 accumulates on every run
        emit(enc_ri(OP_HALT, 0, 8'h00));
        load_program();
        start_and_check();

        // restart from halted so r6 accumulates again
        start_and_check();

        // imem locked while running and an unmapped address
        prog_len = 0;
        emit(enc_ri(OP_JMP, 0, 8'h00));             // spin at word 0
        load_program();
        apb_write(`CORE_ADDR_CTRL, 32'h1, err);
        apb_read(`CORE_ADDR_STATUS, d, err);
        check_eq("prdata status", 32'(HOST_RUNNING), d);
        old = prog[10];
        apb_write(`CORE_ADDR_IMEM + 12'd40, {16'h0, ~old}, err);
        check_true(err, "no pslverr on an imem write while the core runs");
        apb_read(`CORE_ADDR_IMEM + 12'd40, d, err);
        check_eq("prdata imem[10]", {16'h0, old}, d);
        apb_read(12'h200, d, err);
        check_true(err, "no pslverr on a read of unmapped address 0x200");
        apb_write(`CORE_ADDR_CTRL, 32'h0, err);
        apb_read(`CORE_ADDR_STATUS, d, err);
        check_eq("prdata status", 32'(HOST_IDLE), d);

        errors = errors + int'(u_mini_core_top.u_props.fail_cnt);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+hw
hw/core_pkg.sv
hw/gen_dff.sv
hw/reg_file.sv
hw/exec_stage.sv
hw/decode_stage.sv
hw/fetch_stage.sv
hw/apb_host_port.sv
hw/mini_core_top.sv
bench/mini_core_properties.sv
bench/mini_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mini core testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module mini_core_tb -Mdir obj_dir -o mini_core_sim
./obj_dir/mini_core_sim | tee sim.log
if grep -q "Some tests failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
